//--- design/bip_control.sv
`timescale 1ns/1ps

module bip_control #(
   parameter int PROG_ADDR_W = 11
) (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  bip_pkg::word_t         i_instr,
   output logic [PROG_ADDR_W-1:0] o_pc,
   output bip_pkg::operand_t      o_operand,
   output bip_pkg::ctrl_t         o_ctrl,
   output logic                   o_halt
);

   localparam int NB_WORD   = bip_pkg::NB_WORD;
   localparam int NB_OPCODE = bip_pkg::NB_OPCODE;

   // no strobe, accumulator kept
   localparam bip_pkg::ctrl_t CTRL_IDLE = '{
      acc_src: bip_pkg::ACC_SRC_HOLD,
      sel_imm: 1'b0,
      op_add:  1'b0,
      wr_acc:  1'b0,
      mem_wr:  1'b0,
      mem_rd:  1'b0
   };

   logic [PROG_ADDR_W-1:0] pc;
   bip_pkg::opcode_e       opcode;
   bip_pkg::ctrl_t         ctrl;
   logic                   pc_en;

   assign opcode    = bip_pkg::opcode_e'(i_instr[NB_WORD-1 -: NB_OPCODE]);
   assign o_operand = i_instr[bip_pkg::NB_OPERAND-1:0];

   // program counter, stops only on halt
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc <= '0;
      end else if (pc_en) begin
         pc <= pc + 1'b1;
      end
   end

   // opcode decode
   always_comb begin
      ctrl  = CTRL_IDLE;
      pc_en = 1'b1;
      if (!i_rst) begin                 // strobes stay low while loading
         case (opcode)
            bip_pkg::OP_HALT: begin
               pc_en = 1'b0;
            end
            bip_pkg::OP_STORE: begin
               ctrl.mem_wr = 1'b1;
            end
            bip_pkg::OP_LOAD: begin
               ctrl.acc_src = bip_pkg::ACC_SRC_MEM;
               ctrl.wr_acc  = 1'b1;
               ctrl.mem_rd  = 1'b1;
            end
            bip_pkg::OP_LOADI: begin
               ctrl.acc_src = bip_pkg::ACC_SRC_IMM;
               ctrl.wr_acc  = 1'b1;
            end
            bip_pkg::OP_ADD: begin
               ctrl.acc_src = bip_pkg::ACC_SRC_ALU;
               ctrl.op_add  = 1'b1;
               ctrl.wr_acc  = 1'b1;
               ctrl.mem_rd  = 1'b1;
            end
            bip_pkg::OP_ADDI: begin
               ctrl.acc_src = bip_pkg::ACC_SRC_ALU;
               ctrl.sel_imm = 1'b1;
               ctrl.op_add  = 1'b1;
               ctrl.wr_acc  = 1'b1;
            end
            bip_pkg::OP_SUB: begin
               ctrl.acc_src = bip_pkg::ACC_SRC_ALU;
               ctrl.wr_acc  = 1'b1;
               ctrl.mem_rd  = 1'b1;
            end
            bip_pkg::OP_SUBI: begin
               ctrl.acc_src = bip_pkg::ACC_SRC_ALU;
               ctrl.sel_imm = 1'b1;
               ctrl.wr_acc  = 1'b1;
            end
            default: begin
               ctrl = CTRL_IDLE;        // unknown opcode, pc advances only
            end
         endcase
      end
   end

   assign o_pc   = pc;
   assign o_ctrl = ctrl;
   assign o_halt = ~i_rst & (opcode == bip_pkg::OP_HALT);

endmodule

//--- design/bip_data_mem.sv
`timescale 1ns/1ps

module bip_data_mem #(
   parameter int DATA_ADDR_W = 10
) (
   input  logic                   i_clk,
   input  logic                   i_we,
   input  logic [DATA_ADDR_W-1:0] i_addr,
   input  bip_pkg::word_t         i_wdata,
   output bip_pkg::word_t         o_rdata
);

   localparam int DEPTH = 2 ** DATA_ADDR_W;

   bip_pkg::word_t mem [DEPTH];          // variable store

   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_addr] <= i_wdata;         // store writes at end of cycle
      end
   end

   // read for load, add and sub of a variable
   assign o_rdata = mem[i_addr];

endmodule

//--- design/bip_datapath.sv
`timescale 1ns/1ps

module bip_datapath (
   input  logic              i_clk,
   input  logic              i_rst,
   input  bip_pkg::ctrl_t    i_ctrl,
   input  bip_pkg::operand_t i_operand,
   input  bip_pkg::word_t    i_mem_data,
   output bip_pkg::word_t    o_acc
);

   localparam int NB_EXT = bip_pkg::NB_WORD - bip_pkg::NB_OPERAND;

   bip_pkg::word_t acc;
   bip_pkg::word_t acc_next;
   bip_pkg::word_t imm_ext;
   bip_pkg::word_t alu_b;
   bip_pkg::word_t alu_res;

   // operand bit 10 is the sign
   assign imm_ext = {{NB_EXT{i_operand[bip_pkg::NB_OPERAND-1]}}, i_operand};

   // second alu operand
   always_comb begin
      if (i_ctrl.sel_imm) begin
         alu_b = imm_ext;
      end else begin
         alu_b = i_mem_data;
      end
   end

   // 16-bit wraparound on both paths
   always_comb begin
      if (i_ctrl.op_add) begin
         alu_res = acc + alu_b;
      end else begin
         alu_res = acc - alu_b;
      end
   end

   // accumulator source mux
   always_comb begin
      case (i_ctrl.acc_src)
         bip_pkg::ACC_SRC_MEM: begin
            acc_next = i_mem_data;
         end
         bip_pkg::ACC_SRC_IMM: begin
            acc_next = imm_ext;
         end
         bip_pkg::ACC_SRC_ALU: begin
            acc_next = alu_res;
         end
         default: begin
            acc_next = acc;             // hold, store keeps acc
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         acc <= '0;
      end else if (i_ctrl.wr_acc) begin
         acc <= acc_next;
      end
   end

   assign o_acc = acc;                  // also the store write data

endmodule

//--- design/bip_pkg.sv
package bip_pkg;

   // field widths of the instruction word
   localparam int NB_WORD    = 16;      // instruction and data width
   localparam int NB_OPCODE  = 5;       // upper bits of the instruction
   localparam int NB_OPERAND = 11;      // immediate or variable address

   typedef logic [NB_WORD-1:0]    word_t;
   typedef logic [NB_OPERAND-1:0] operand_t;

   // instruction set, any other opcode only advances the pc
   typedef enum logic [NB_OPCODE-1:0] {
      OP_HALT  = 5'd0,
      OP_STORE = 5'd1,                  // mem[operand] = acc
      OP_LOAD  = 5'd2,                  // acc = mem[operand]
      OP_LOADI = 5'd3,                  // acc = sext(operand)
      OP_ADD   = 5'd4,
      OP_ADDI  = 5'd5,
      OP_SUB   = 5'd6,
      OP_SUBI  = 5'd7
   } opcode_e;

   // accumulator input mux
   typedef enum logic [1:0] {
      ACC_SRC_MEM  = 2'd0,              // data memory read value
      ACC_SRC_IMM  = 2'd1,              // sign-extended operand
      ACC_SRC_ALU  = 2'd2,              // add/sub result
      ACC_SRC_HOLD = 2'd3               // keep current value, store
   } acc_src_e;

   // decoded control, 7 bits
   typedef struct packed {
      acc_src_e acc_src;
      logic     sel_imm;                // alu operand b is the immediate
      logic     op_add;                 // 1 add, 0 subtract
      logic     wr_acc;                 // accumulator write enable
      logic     mem_wr;                 // data memory write strobe
      logic     mem_rd;                 // data memory read strobe
   } ctrl_t;

endpackage

//--- design/bip_program_mem.sv
`timescale 1ns/1ps

module bip_program_mem #(
   parameter int PROG_ADDR_W = 11
) (
   input  logic                   i_clk,
   input  logic                   i_we,
   input  logic [PROG_ADDR_W-1:0] i_waddr,
   input  bip_pkg::word_t         i_wdata,
   input  logic [PROG_ADDR_W-1:0] i_raddr,
   output bip_pkg::word_t         o_rdata
);

   localparam int DEPTH = 2 ** PROG_ADDR_W;

   bip_pkg::word_t mem [DEPTH];          // instruction store

   // load port, used only while the core is in reset
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata = mem[i_raddr];        // fetch at pc, no latency

endmodule

//--- design/bip_top.sv
`timescale 1ns/1ps

module bip_top #(
   parameter int PROG_ADDR_W = 11,
   parameter int DATA_ADDR_W = 10
) (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_prog_we,
   input  logic [PROG_ADDR_W-1:0] i_prog_addr,
   input  bip_pkg::word_t         i_prog_data,
   output logic [PROG_ADDR_W-1:0] o_pc,
   output bip_pkg::word_t         o_acc,
   output logic                   o_halt,
   output logic                   o_mem_rd
);

   logic [PROG_ADDR_W-1:0] pc;
   logic                   prog_we;
   bip_pkg::word_t         instr;
   bip_pkg::operand_t      operand;
   bip_pkg::ctrl_t         ctrl;
   bip_pkg::word_t         acc;
   bip_pkg::word_t         mem_rdata;
   logic [DATA_ADDR_W-1:0] data_addr;

   assign prog_we   = i_prog_we & i_rst;           // loading only under reset
   assign data_addr = operand[DATA_ADDR_W-1:0];    // low operand bits

   bip_control #(
      .PROG_ADDR_W(PROG_ADDR_W)
   ) u_control (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_instr  (instr),
      .o_pc     (pc),
      .o_operand(operand),
      .o_ctrl   (ctrl),
      .o_halt   (o_halt)
   );

   bip_datapath u_datapath (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_ctrl    (ctrl),
      .i_operand (operand),
      .i_mem_data(mem_rdata),
      .o_acc     (acc)
   );

   bip_program_mem #(
      .PROG_ADDR_W(PROG_ADDR_W)
   ) u_program_mem (
      .i_clk  (i_clk),
      .i_we   (prog_we),
      .i_waddr(i_prog_addr),
      .i_wdata(i_prog_data),
      .i_raddr(pc),
      .o_rdata(instr)
   );

   bip_data_mem #(
      .DATA_ADDR_W(DATA_ADDR_W)
   ) u_data_mem (
      .i_clk  (i_clk),
      .i_we   (ctrl.mem_wr),
      .i_addr (data_addr),
      .i_wdata(acc),
      .o_rdata(mem_rdata)
   );

   assign o_pc     = pc;
   assign o_acc    = acc;
   assign o_mem_rd = ctrl.mem_rd;                  // bus status only

endmodule

//--- files.f
design/bip_pkg.sv
design/bip_control.sv
design/bip_datapath.sv
design/bip_program_mem.sv
design/bip_data_mem.sv
design/bip_top.sv
tests/bip_tb.sv

//--- tests/bip_tb.sv
`timescale 1ns/1ps

module bip_tb;

   localparam int PROG_ADDR_W = 11;
   localparam int DATA_ADDR_W = 10;
   localparam int CLK_PERIOD  = 8;
   localparam int N_RAND      = 3;      // random programs
   localparam int RAND_LEN    = 200;    // instructions per random program, halt included
   localparam int DIR_MAX     = 40;     // upper bound on the directed program
   // load and execute each word once, plus reset, halt hold and slack per program
   localparam int TOTAL_STEPS = (DIR_MAX + N_RAND * RAND_LEN) * 2 + (N_RAND + 1) * 16;

   typedef logic [PROG_ADDR_W-1:0] pc_t;

   logic                clk;
   logic                rst;
   logic                prog_we;
   pc_t                 prog_addr;
   bip_pkg::word_t      prog_data;
   pc_t                 dut_pc;
   bip_pkg::word_t      dut_acc;
   logic                dut_halt;
   logic                dut_mem_rd;

   bip_pkg::word_t      prog_q[$];
   bip_pkg::word_t      model_prog [2**PROG_ADDR_W];
   bip_pkg::word_t      model_mem [2**DATA_ADDR_W];
   pc_t                 model_pc;
   bip_pkg::word_t      model_acc;
   logic                check_en;
   logic [15:0]         lfsr_state;

   bip_top #(
      .PROG_ADDR_W(PROG_ADDR_W),
      .DATA_ADDR_W(DATA_ADDR_W)
   ) u_dut (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_prog_we  (prog_we),
      .i_prog_addr(prog_addr),
      .i_prog_data(prog_data),
      .o_pc       (dut_pc),
      .o_acc      (dut_acc),
      .o_halt     (dut_halt),
      .o_mem_rd   (dut_mem_rd)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic bip_pkg::word_t make_instr(input logic [4:0] op,
                                                 input bip_pkg::operand_t opnd);
      return {op, opnd};
   endfunction

   // galois lfsr, taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   function automatic int unsigned take_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = (v << 1) | lfsr_state[0];    // one step per bit
      end
      return v;
   endfunction

   // one instruction on the model state
   function automatic void exec_model(input bip_pkg::word_t instr);
      logic [4:0]             op;
      bip_pkg::operand_t      opnd;
      bip_pkg::word_t         imm;
      logic [DATA_ADDR_W-1:0] addr;
      op   = instr[15:11];
      opnd = instr[10:0];
      imm  = {{5{opnd[10]}}, opnd};       // sign extension from bit 10
      addr = opnd[DATA_ADDR_W-1:0];
      case (op)
         bip_pkg::OP_HALT:  ;
         bip_pkg::OP_STORE: model_mem[addr] = model_acc;
         bip_pkg::OP_LOAD:  model_acc = model_mem[addr];
         bip_pkg::OP_LOADI: model_acc = imm;
         bip_pkg::OP_ADD:   model_acc = model_acc + model_mem[addr];
         bip_pkg::OP_ADDI:  model_acc = model_acc + imm;
         bip_pkg::OP_SUB:   model_acc = model_acc - model_mem[addr];
         bip_pkg::OP_SUBI:  model_acc = model_acc - imm;
         default:           ;             // no effect besides the pc
      endcase
      if (op != bip_pkg::OP_HALT) begin
         model_pc = model_pc + 1'b1;
      end
   endfunction

   task automatic word_check(input string what, input bip_pkg::word_t got,
                             input bip_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic pc_check(input string what, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic bit_check(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   // model follows the dut edge by edge
   always @(posedge clk) begin
      if (rst) begin
         model_pc  = '0;
         model_acc = '0;
      end else begin
         exec_model(model_prog[model_pc]);
      end
   end

   // outputs are stable mid cycle
   always @(negedge clk) begin
      bip_pkg::word_t cur;
      logic [4:0]     op;
      logic           exp_halt;
      logic           exp_rd;
      if (check_en) begin
         cur      = model_prog[model_pc];
         op       = cur[15:11];
         exp_halt = !rst && (op == bip_pkg::OP_HALT);
         exp_rd   = !rst && (op == bip_pkg::OP_LOAD || op == bip_pkg::OP_ADD ||
                             op == bip_pkg::OP_SUB);
         pc_check("o_pc", dut_pc, model_pc);
         word_check("o_acc", dut_acc, model_acc);
         bit_check("o_halt", dut_halt, exp_halt);
         bit_check("o_mem_rd", dut_mem_rd, exp_rd);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic build_directed();
      prog_q.delete();
      prog_q.push_back(make_instr(bip_pkg::OP_LOADI, 11'h400));   // first cycle, fc00
      prog_q.push_back(make_instr(bip_pkg::OP_ADDI,  11'h7FF));
      prog_q.push_back(make_instr(bip_pkg::OP_SUBI,  11'h401));
      prog_q.push_back(make_instr(bip_pkg::OP_LOADI, 11'h7FF));
      prog_q.push_back(make_instr(bip_pkg::OP_ADDI,  11'h001));   // wraps to zero
      prog_q.push_back(make_instr(bip_pkg::OP_SUBI,  11'h001));   // wraps to ffff
      prog_q.push_back(make_instr(bip_pkg::OP_LOADI, 11'h3FF));
      prog_q.push_back(make_instr(bip_pkg::OP_ADDI,  11'h3FF));
      prog_q.push_back(make_instr(bip_pkg::OP_LOADI, 11'h123));
      prog_q.push_back(make_instr(bip_pkg::OP_STORE, 11'h005));
      prog_q.push_back(make_instr(bip_pkg::OP_LOADI, 11'h000));
      prog_q.push_back(make_instr(bip_pkg::OP_ADD,   11'h005));
      prog_q.push_back(make_instr(bip_pkg::OP_ADD,   11'h005));
      prog_q.push_back(make_instr(bip_pkg::OP_SUB,   11'h005));
      prog_q.push_back(make_instr(bip_pkg::OP_LOAD,  11'h005));
      prog_q.push_back(make_instr(bip_pkg::OP_SUBI,  11'h400));
      prog_q.push_back(make_instr(bip_pkg::OP_STORE, 11'h7FF));   // address bit 10 dropped
      prog_q.push_back(make_instr(bip_pkg::OP_LOADI, 11'h001));
      prog_q.push_back(make_instr(bip_pkg::OP_ADD,   11'h3FF));
      prog_q.push_back(make_instr(bip_pkg::OP_SUB,   11'h7FF));
      prog_q.push_back(make_instr(5'd8,  11'h155));
      prog_q.push_back(make_instr(5'd19, 11'h2AA));
      prog_q.push_back(make_instr(5'd31, 11'h7FF));
      prog_q.push_back(make_instr(bip_pkg::OP_LOAD,  11'h005));
      prog_q.push_back(make_instr(bip_pkg::OP_HALT,  11'h000));
   endtask

   task automatic build_random();
      int unsigned       sel;
      logic [4:0]        op;
      bip_pkg::operand_t opnd;
      int unsigned       stored_q[$];
      prog_q.delete();
      for (int i = 0; i < RAND_LEN - 1; i++) begin
         sel  = take_bits(4);
         opnd = bip_pkg::operand_t'(take_bits(11));
         if (sel >= 14) begin
            op = 5'(8 + take_bits(5) % 24);   // unknown opcode
         end else begin
            op = 5'(1 + sel % 7);
         end
         if (op == bip_pkg::OP_LOAD || op == bip_pkg::OP_ADD || op == bip_pkg::OP_SUB) begin
            if (stored_q.size() == 0) begin
               op = bip_pkg::OP_LOADI;          // nothing written yet
            end else begin
               opnd = bip_pkg::operand_t'(stored_q[take_bits(8) % stored_q.size()]);
            end
         end else if (op == bip_pkg::OP_STORE) begin
            stored_q.push_back(opnd[DATA_ADDR_W-1:0]);
         end
         prog_q.push_back(make_instr(op, opnd));
      end
      prog_q.push_back(make_instr(bip_pkg::OP_HALT, '0));
   endtask

   // load under reset, release, wait for halt
   task automatic run_program();
      next_cycle();
      rst       = 1'b1;
      check_en  = 1'b1;
      prog_we   = 1'b1;
      prog_addr = '0;
      prog_data = make_instr(bip_pkg::OP_LOAD, 11'h005);   // read strobe must stay low
      next_cycle();
      foreach (prog_q[i]) begin
         prog_we       = 1'b1;
         prog_addr     = pc_t'(i);
         prog_data     = prog_q[i];
         model_prog[i] = prog_q[i];
         next_cycle();
      end
      prog_we = 1'b0;
      repeat (2) next_cycle();
      rst = 1'b0;
      @(negedge clk);
      while (dut_halt !== 1'b1) begin
         @(negedge clk);
      end
      // program port is closed out of reset
      next_cycle();
      prog_we   = 1'b1;
      prog_addr = model_pc;
      prog_data = make_instr(bip_pkg::OP_LOADI, 11'h2AA);
      repeat (10) next_cycle();        // halt must hold pc and acc
      prog_we = 1'b0;
   endtask

   initial begin
      #((TOTAL_STEPS + 20) * CLK_PERIOD);
      $display("the processor never halted before the watchdog limit");
      $display("Testbench failed");
      $fatal(1);
   end

   initial begin
      rst        = 1'b1;
      prog_we    = 1'b0;
      prog_addr  = '0;
      prog_data  = '0;
      check_en   = 1'b0;
      model_pc   = '0;
      model_acc  = '0;
      lfsr_state = 16'd79;
      build_directed();
      run_program();
      for (int k = 0; k < N_RAND; k++) begin
         build_random();
         run_program();
      end
      $display("Testbench passed");
      $finish;
   end

endmodule
